/* logic/sys_ctrl_config.svh */
`ifndef SYS_CTRL_CONFIG_SVH
`define SYS_CTRL_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

// address and data word width
`define SC_ADDR_W 32

// segment selector width
`define SC_SEL_W 16

//////////////////////////////////////////////////////////////////////
// interrupt vectors
//////////////////////////////////////////////////////////////////////

`define SC_NUM_VEC 16
`define SC_VEC_W 4

// descriptor for vector n sits at base + n * stride
`define SC_IDT_BASE 32'h4000
`define SC_IDT_STRIDE 32'd8

`endif

/* logic/sc_ctrl_pkg.sv */
`include "sys_ctrl_config.svh"

package sc_ctrl_pkg;

  // one flush line per pipeline stage
  typedef struct packed {
    logic fetch;
    logic decode_0;
    logic decode_1;
    logic register;
    logic address;
    logic execute;
    logic writeback;
  } flush_t;

  // complete redirect of front end and architectural state
  typedef struct packed {
    logic                  fetch_load;
    logic [`SC_ADDR_W-1:0] fetch_addr;
    logic                  load_cs;
    logic [`SC_SEL_W-1:0]  cs;
    logic                  load_eip;
    logic [`SC_ADDR_W-1:0] eip;
    logic                  load_eflags;
    logic [`SC_ADDR_W-1:0] eflags;
    flush_t                flush;
  } redirect_t;

  // jump request from execute
  typedef struct packed {
    logic                  load;
    logic [`SC_ADDR_W-1:0] address;
    logic                  load_cs;
    logic [`SC_SEL_W-1:0]  cs;
  } jump_req_t;

  // one word popped off the stack
  typedef struct packed {
    logic                  valid;
    logic [`SC_ADDR_W-1:0] data;
  } pop_t;

endpackage

/* logic/sc_mem_pkg.sv */
`include "sys_ctrl_config.svh"

package sc_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // read port toward memory
  //////////////////////////////////////////////////////////////////////

  // address phase, held until mem_ready
  typedef struct packed {
    logic                  valid;
    logic [`SC_ADDR_W-1:0] addr;
  } mem_rd_req_t;

  //////////////////////////////////////////////////////////////////////
  // read data coming back
  //////////////////////////////////////////////////////////////////////

  // data phase, taken while mem_dp_ready is high
  typedef struct packed {
    logic                  valid;
    logic [`SC_ADDR_W-1:0] data;
  } mem_rd_rsp_t;

endpackage

/* logic/int_pending.sv */
`timescale 1ns/100ps

`include "sys_ctrl_config.svh"

module int_pending (
  input  logic                  or_int_vec,
  input  logic                  rst,
  input  logic [`SC_NUM_VEC-1:0] int_vec,
  input  logic                  hold_int,
  input  logic                  served,
  input  logic [`SC_VEC_W-1:0]  served_vec,
  output logic                  pending_any,
  output logic                  no_hold,
  output logic [`SC_VEC_W-1:0]  vec
);

  localparam int VEC_W = `SC_VEC_W;

  logic [`SC_NUM_VEC-1:0] pend_q;
  logic [`SC_NUM_VEC-1:0] clr_mask;
  logic [`SC_NUM_VEC-1:0] pend_d;
  logic [`SC_VEC_W-1:0]   vec_sel;

  // one-hot of the vector that idt_fetch just finished
  assign clr_mask = {{(`SC_NUM_VEC - 1){1'b0}}, served} << served_vec;

  // a fresh pulse on the same line keeps the bit set
  assign pend_d = (pend_q & ~clr_mask) | int_vec;

  always_ff @(posedge or_int_vec) begin
    if (rst) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  // lowest numbered line wins
  always_comb begin
    vec_sel = '0;
    for (int i = `SC_NUM_VEC - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        vec_sel = VEC_W'(i);
      end
    end
  end

  assign pending_any = |pend_q;
  assign no_hold     = pending_any & ~hold_int;
  assign vec         = vec_sel;

endmodule

/* logic/idt_fetch.sv */
`timescale 1ns/100ps

`include "sys_ctrl_config.svh"

module idt_fetch (
  input  logic                     or_int_vec,
  input  logic                     rst,
  input  logic                     no_hold,
  input  logic [`SC_VEC_W-1:0]     vec,
  input  logic                     iret_busy,
  input  logic                     mem_ready,
  input  sc_mem_pkg::mem_rd_rsp_t  rd_rsp,
  output sc_mem_pkg::mem_rd_req_t  rd_req,
  output logic                     mem_dp_ready,
  output logic                     served,
  output logic [`SC_VEC_W-1:0]     served_vec,
  output sc_ctrl_pkg::redirect_t   redirect
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RSP
  } state_e;

  state_e                           state_q;
  logic                             start;
  logic [`SC_VEC_W-1:0]             vec_q;
  logic [`SC_ADDR_W-1:0]            addr_q;
  logic [`SC_ADDR_W-1:0]            swapped;
  logic                             done_q;
  logic [`SC_SEL_W-1:0]             cs_q;
  logic [`SC_ADDR_W-`SC_SEL_W-1:0]  ip_q;

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  // no new interrupt while an iretd is unwinding
  assign start  = (state_q == ST_IDLE) && no_hold && !iret_busy;
  assign served = (state_q == ST_RSP) && rd_rsp.valid;

  always_ff @(posedge or_int_vec) begin
    if (rst) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= served;
      case (state_q)
        ST_IDLE: if (start) state_q <= ST_REQ;
        ST_REQ:  if (mem_ready) state_q <= ST_RSP;
        ST_RSP:  if (rd_rsp.valid) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // vector and descriptor address frozen for the whole read
  always_ff @(posedge or_int_vec) begin
    if (start) begin
      vec_q  <= vec;
      addr_q <= `SC_IDT_BASE
                + `SC_IDT_STRIDE * {{(`SC_ADDR_W - `SC_VEC_W){1'b0}}, vec};
    end
  end

  assign rd_req.valid = (state_q == ST_REQ);
  assign rd_req.addr  = addr_q;
  assign mem_dp_ready = (state_q == ST_RSP);
  assign served_vec   = vec_q;

  //////////////////////////////////////////////////////////////////////
  // descriptor decode
  //////////////////////////////////////////////////////////////////////

  // descriptor word arrives in the opposite byte order
  assign swapped = {rd_rsp.data[7:0], rd_rsp.data[15:8],
                    rd_rsp.data[23:16], rd_rsp.data[31:24]};

  always_ff @(posedge or_int_vec) begin
    if (served) begin
      cs_q <= swapped[`SC_ADDR_W-1:`SC_ADDR_W-`SC_SEL_W];
      ip_q <= swapped[`SC_ADDR_W-`SC_SEL_W-1:0];
    end
  end

  // one cycle redirect to the handler, writeback left alone
  always_comb begin
    redirect                 = '0;
    redirect.fetch_load      = done_q;
    redirect.fetch_addr      = {{`SC_SEL_W{1'b0}}, ip_q};
    redirect.load_cs         = done_q;
    redirect.cs              = cs_q;
    redirect.flush.fetch     = done_q;
    redirect.flush.decode_0  = done_q;
    redirect.flush.decode_1  = done_q;
    redirect.flush.register  = done_q;
    redirect.flush.address   = done_q;
    redirect.flush.execute   = done_q;
  end

endmodule

/* logic/iret_unwind.sv */
`timescale 1ns/100ps

`include "sys_ctrl_config.svh"

module iret_unwind (
  input  logic                   or_int_vec,
  input  logic                   rst,
  input  logic                   iretd,
  input  sc_ctrl_pkg::pop_t      pop,
  output logic                   busy,
  output sc_ctrl_pkg::redirect_t redirect
);

  // pop order on the stack is eip, cs, eflags
  localparam logic [1:0] STEP_IDLE   = 2'd0;
  localparam logic [1:0] STEP_EIP    = 2'd1;
  localparam logic [1:0] STEP_CS     = 2'd2;
  localparam logic [1:0] STEP_EFLAGS = 2'd3;

  logic [1:0]            step_q;
  logic                  pop_take;
  logic                  cs_load_q;
  logic                  final_q;
  logic [`SC_ADDR_W-1:0] eip_q;
  logic [`SC_SEL_W-1:0]  cs_q;
  logic [`SC_ADDR_W-1:0] eflags_q;

  assign pop_take = (step_q != STEP_IDLE) && pop.valid;

  //////////////////////////////////////////////////////////////////////
  // step counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge or_int_vec) begin
    if (rst) begin
      step_q    <= STEP_IDLE;
      cs_load_q <= 1'b0;
      final_q   <= 1'b0;
    end else begin
      cs_load_q <= pop_take && (step_q == STEP_CS);
      final_q   <= pop_take && (step_q == STEP_EFLAGS);
      if (step_q == STEP_IDLE) begin
        if (iretd && !final_q) begin
          step_q <= STEP_EIP;
        end
      end else if (pop.valid) begin
        // eflags step wraps back to idle
        step_q <= step_q + 2'd1;
      end
    end
  end

  // popped words
  always_ff @(posedge or_int_vec) begin
    if (pop_take && (step_q == STEP_EIP)) begin
      eip_q <= pop.data;
    end
    if (pop_take && (step_q == STEP_CS)) begin
      cs_q <= pop.data[`SC_SEL_W-1:0];
    end
    if (pop_take && (step_q == STEP_EFLAGS)) begin
      eflags_q <= pop.data;
    end
  end

  // halt stays up through the final load cycle
  assign busy = (step_q != STEP_IDLE) || final_q;

  always_comb begin
    redirect                = '0;
    redirect.load_cs        = cs_load_q;
    redirect.cs             = cs_q;
    redirect.fetch_load     = final_q;
    redirect.fetch_addr     = eip_q;
    redirect.load_eip       = final_q;
    redirect.eip            = eip_q;
    redirect.load_eflags    = final_q;
    redirect.eflags         = eflags_q;
    redirect.flush.fetch    = busy;
    redirect.flush.decode_0 = final_q;
    redirect.flush.decode_1 = final_q;
    redirect.flush.register = final_q;
    redirect.flush.address  = final_q;
  end

endmodule

/* logic/redirect_merge.sv */
`timescale 1ns/100ps

`include "sys_ctrl_config.svh"

module redirect_merge (
  input  logic                   or_int_vec,
  input  logic                   rst,
  input  sc_ctrl_pkg::jump_req_t jump,
  input  sc_ctrl_pkg::redirect_t int_redirect,
  input  sc_ctrl_pkg::redirect_t iret_redirect,
  output sc_ctrl_pkg::flush_t    flush,
  output logic                   fetch_load,
  output logic [`SC_ADDR_W-1:0]  fetch_load_address,
  output logic                   reg_load_cs,
  output logic [`SC_SEL_W-1:0]   reg_cs,
  output logic                   reg_load_eip,
  output logic [`SC_ADDR_W-1:0]  reg_eip,
  output logic                   reg_load_eflags,
  output logic [`SC_ADDR_W-1:0]  reg_eflags
);

  sc_ctrl_pkg::jump_req_t jump_q;
  sc_ctrl_pkg::redirect_t jmp_redirect;
  sc_ctrl_pkg::redirect_t src [3];

  //////////////////////////////////////////////////////////////////////
  // jump register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge or_int_vec) begin
    if (rst) begin
      jump_q.load    <= 1'b0;
      jump_q.load_cs <= 1'b0;
    end else begin
      jump_q.load    <= jump.load;
      jump_q.load_cs <= jump.load_cs;
    end
    jump_q.address <= jump.address;
    jump_q.cs      <= jump.cs;
  end

  always_comb begin
    jmp_redirect            = '0;
    jmp_redirect.fetch_load = jump_q.load;
    jmp_redirect.fetch_addr = jump_q.address;
    jmp_redirect.load_cs    = jump_q.load & jump_q.load_cs;
    jmp_redirect.cs         = jump_q.cs;
    jmp_redirect.flush      = {{6{jump_q.load}}, 1'b0};
  end

  //////////////////////////////////////////////////////////////////////
  // merge, later entries take priority for values
  //////////////////////////////////////////////////////////////////////

  assign src[0] = int_redirect;
  assign src[1] = iret_redirect;
  assign src[2] = jmp_redirect;

  always_comb begin
    flush              = '0;
    fetch_load         = 1'b0;
    fetch_load_address = '0;
    reg_load_cs        = 1'b0;
    reg_cs             = '0;
    reg_load_eip       = 1'b0;
    reg_eip            = '0;
    reg_load_eflags    = 1'b0;
    reg_eflags         = '0;
    for (int i = 0; i < 3; i++) begin
      flush = sc_ctrl_pkg::flush_t'(flush | src[i].flush);
      fetch_load      = fetch_load | src[i].fetch_load;
      reg_load_cs     = reg_load_cs | src[i].load_cs;
      reg_load_eip    = reg_load_eip | src[i].load_eip;
      reg_load_eflags = reg_load_eflags | src[i].load_eflags;
      if (src[i].fetch_load) fetch_load_address = src[i].fetch_addr;
      if (src[i].load_cs) reg_cs = src[i].cs;
      if (src[i].load_eip) reg_eip = src[i].eip;
      if (src[i].load_eflags) reg_eflags = src[i].eflags;
    end
  end

endmodule

/* logic/sys_ctrl_top.sv */
`timescale 1ns/100ps

`include "sys_ctrl_config.svh"

module sys_ctrl_top (
  input  logic                   or_int_vec,
  input  logic                   rst,
  input  logic [`SC_NUM_VEC-1:0] int_vec,
  input  logic                   hold_int,
  output logic                   pending_int,
  output logic                   mem_valid,
  input  logic                   mem_ready,
  output logic [`SC_ADDR_W-1:0]  mem_address,
  input  logic                   mem_dp_valid,
  output logic                   mem_dp_ready,
  input  logic [`SC_ADDR_W-1:0]  mem_dp_read_data,
  input  logic                   iretd,
  output logic                   iretd_halt,
  input  logic                   iretd_pop_valid,
  input  logic [`SC_ADDR_W-1:0]  iretd_pop_data,
  input  logic                   jump_load,
  input  logic [`SC_ADDR_W-1:0]  jump_load_address,
  input  logic                   jump_load_cs,
  input  logic [`SC_SEL_W-1:0]   jump_cs,
  output logic                   flush_fetch,
  output logic                   flush_decode_0,
  output logic                   flush_decode_1,
  output logic                   flush_register,
  output logic                   flush_address,
  output logic                   flush_execute,
  output logic                   flush_writeback,
  output logic                   fetch_load,
  output logic [`SC_ADDR_W-1:0]  fetch_load_address,
  output logic                   reg_load_cs,
  output logic [`SC_SEL_W-1:0]   reg_cs,
  output logic                   reg_load_eip,
  output logic [`SC_ADDR_W-1:0]  reg_eip,
  output logic                   reg_load_eflags,
  output logic [`SC_ADDR_W-1:0]  reg_eflags
);

  sc_ctrl_pkg::jump_req_t  jump_req;
  sc_ctrl_pkg::pop_t       pop;
  sc_ctrl_pkg::redirect_t  int_redirect;
  sc_ctrl_pkg::redirect_t  iret_redirect;
  sc_ctrl_pkg::flush_t     flush;
  sc_mem_pkg::mem_rd_req_t rd_req;
  sc_mem_pkg::mem_rd_rsp_t rd_rsp;
  logic                    pending_any;
  logic                    no_hold;
  logic                    served;
  logic                    iret_busy;
  logic [`SC_VEC_W-1:0]    vec;
  logic [`SC_VEC_W-1:0]    served_vec;

  // flat ports into structs
  assign jump_req = '{load: jump_load, address: jump_load_address,
                      load_cs: jump_load_cs, cs: jump_cs};
  assign pop      = '{valid: iretd_pop_valid, data: iretd_pop_data};
  assign rd_rsp   = '{valid: mem_dp_valid, data: mem_dp_read_data};

  int_pending u_int_pending (
    .or_int_vec (or_int_vec),
    .rst        (rst),
    .int_vec    (int_vec),
    .hold_int   (hold_int),
    .served     (served),
    .served_vec (served_vec),
    .pending_any(pending_any),
    .no_hold    (no_hold),
    .vec        (vec)
  );

  idt_fetch u_idt_fetch (
    .or_int_vec  (or_int_vec),
    .rst         (rst),
    .no_hold     (no_hold),
    .vec         (vec),
    .iret_busy   (iret_busy),
    .mem_ready   (mem_ready),
    .rd_rsp      (rd_rsp),
    .rd_req      (rd_req),
    .mem_dp_ready(mem_dp_ready),
    .served      (served),
    .served_vec  (served_vec),
    .redirect    (int_redirect)
  );

  iret_unwind u_iret_unwind (
    .or_int_vec(or_int_vec),
    .rst       (rst),
    .iretd     (iretd),
    .pop       (pop),
    .busy      (iret_busy),
    .redirect  (iret_redirect)
  );

  redirect_merge u_redirect_merge (
    .or_int_vec        (or_int_vec),
    .rst               (rst),
    .jump              (jump_req),
    .int_redirect      (int_redirect),
    .iret_redirect     (iret_redirect),
    .flush             (flush),
    .fetch_load        (fetch_load),
    .fetch_load_address(fetch_load_address),
    .reg_load_cs       (reg_load_cs),
    .reg_cs            (reg_cs),
    .reg_load_eip      (reg_load_eip),
    .reg_eip           (reg_eip),
    .reg_load_eflags   (reg_load_eflags),
    .reg_eflags        (reg_eflags)
  );

  // structs back out to flat ports
  assign pending_int     = pending_any;
  assign iretd_halt      = iret_busy;
  assign mem_valid       = rd_req.valid;
  assign mem_address     = rd_req.addr;
  assign flush_fetch     = flush.fetch;
  assign flush_decode_0  = flush.decode_0;
  assign flush_decode_1  = flush.decode_1;
  assign flush_register  = flush.register;
  assign flush_address   = flush.address;
  assign flush_execute   = flush.execute;
  assign flush_writeback = flush.writeback;

endmodule

/* verif/sys_ctrl_sva.sv */
`timescale 1ns/100ps

`include "sys_ctrl_config.svh"

module sys_ctrl_sva (
  input logic                  or_int_vec,
  input logic                  rst,
  input logic                  pending_int,
  input logic                  mem_valid,
  input logic                  mem_ready,
  input logic [`SC_ADDR_W-1:0] mem_address,
  input logic                  mem_dp_ready,
  input logic                  iretd_halt,
  input logic                  fetch_load,
  input logic                  reg_load_cs,
  input logic                  reg_load_eip,
  input logic                  reg_load_eflags,
  input logic                  flush_fetch,
  input logic                  flush_decode_0,
  input logic                  flush_decode_1,
  input logic                  flush_register,
  input logic                  flush_address,
  input logic                  flush_execute,
  input logic                  flush_writeback
);

  logic ctrl_any;

  assign ctrl_any = pending_int | mem_valid | mem_dp_ready | iretd_halt | fetch_load
                  | reg_load_cs | reg_load_eip | reg_load_eflags | flush_fetch
                  | flush_decode_0 | flush_decode_1 | flush_register | flush_address
                  | flush_execute | flush_writeback;

  fetch_load_pulse: assert property (
    @(posedge or_int_vec) disable iff (rst) fetch_load |=> !fetch_load
  ) else $error("fetch_load stayed high for more than one cycle");

  // address phase held until accepted
  mem_address_held: assert property (
    @(posedge or_int_vec) disable iff (rst)
      mem_valid && !mem_ready |=> $stable(mem_address)
  ) else $error("mem_address changed while the read waited for mem_ready");

  writeback_quiet: assert property (
    @(posedge or_int_vec) !flush_writeback
  ) else $error("flush_writeback was raised");

  reset_quiet: assert property (
    @(posedge or_int_vec) rst |=> !ctrl_any
  ) else $error("control outputs were not low after reset");

endmodule

bind sys_ctrl_top sys_ctrl_sva sva0 (.*);

/* verif/sys_ctrl_tb.sv */
`timescale 1ns/100ps

`include "sys_ctrl_config.svh"

module sys_ctrl_tb;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                   or_int_vec;
  logic                   rst;
  logic [`SC_NUM_VEC-1:0] int_vec;
  logic                   hold_int;
  logic                   pending_int;
  logic                   mem_valid;
  logic                   mem_ready;
  logic [`SC_ADDR_W-1:0]  mem_address;
  logic                   mem_dp_valid;
  logic                   mem_dp_ready;
  logic [`SC_ADDR_W-1:0]  mem_dp_read_data;
  logic                   iretd;
  logic                   iretd_halt;
  logic                   iretd_pop_valid;
  logic [`SC_ADDR_W-1:0]  iretd_pop_data;
  logic                   jump_load;
  logic [`SC_ADDR_W-1:0]  jump_load_address;
  logic                   jump_load_cs;
  logic [`SC_SEL_W-1:0]   jump_cs;
  logic                   flush_fetch;
  logic                   flush_decode_0;
  logic                   flush_decode_1;
  logic                   flush_register;
  logic                   flush_address;
  logic                   flush_execute;
  logic                   flush_writeback;
  logic                   fetch_load;
  logic [`SC_ADDR_W-1:0]  fetch_load_address;
  logic                   reg_load_cs;
  logic [`SC_SEL_W-1:0]   reg_cs;
  logic                   reg_load_eip;
  logic [`SC_ADDR_W-1:0]  reg_eip;
  logic                   reg_load_eflags;
  logic [`SC_ADDR_W-1:0]  reg_eflags;

  int unsigned cycle_count = 0;
  logic [31:0] lfsr;

  sys_ctrl_top dut0 (.*);

  initial begin
    or_int_vec = 1'b0;
    forever #4 or_int_vec = ~or_int_vec;
  end

  always @(posedge or_int_vec) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic logic [31:0] byte_reverse(input logic [31:0] w);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] desc_addr(input logic [31:0] v);
    return `SC_IDT_BASE + `SC_IDT_STRIDE * v;
  endfunction

  function automatic logic [6:0] flush_bits();
    return {flush_fetch, flush_decode_0, flush_decode_1, flush_register,
            flush_address, flush_execute, flush_writeback};
  endfunction

  // drive point just after the rising edge
  task automatic next_cycle();
    @(posedge or_int_vec);
    #1;
  endtask

  // sample point mid cycle
  task automatic settle();
    @(negedge or_int_vec);
  endtask

  task automatic check_eq(input string what, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic pulse_lines(input logic [`SC_NUM_VEC-1:0] lines);
    next_cycle();
    int_vec = lines;
    next_cycle();
    int_vec = '0;
    settle();
  endtask

  // answers one descriptor read with random waits, then checks the redirect
  task automatic serve_read(input logic [31:0] exp_addr);
    logic [31:0] n;
    logic [31:0] word;
    logic [31:0] swapped;
    while (!mem_valid) begin
      next_cycle();
      settle();
    end
    check_eq("mem_address", mem_address, exp_addr);
    take_bits(2, n);
    repeat (n) begin
      next_cycle();
      settle();
      check_eq("mem_valid while stalled", mem_valid, 1'b1);
      check_eq("mem_address while stalled", mem_address, exp_addr);
    end
    next_cycle();
    mem_ready = 1'b1;
    next_cycle();
    mem_ready = 1'b0;
    settle();
    check_eq("mem_valid after accept", mem_valid, 1'b0);
    take_bits(2, n);
    repeat (n) begin
      check_eq("mem_dp_ready", mem_dp_ready, 1'b1);
      check_eq("fetch_load before data", fetch_load, 1'b0);
      next_cycle();
      settle();
    end
    check_eq("mem_dp_ready", mem_dp_ready, 1'b1);
    take_bits(32, word);
    next_cycle();
    mem_dp_valid     = 1'b1;
    mem_dp_read_data = word;
    next_cycle();
    mem_dp_valid = 1'b0;
    settle();
    swapped = byte_reverse(word);
    check_eq("fetch_load", fetch_load, 1'b1);
    check_eq("fetch_load_address", fetch_load_address, {16'h0, swapped[15:0]});
    check_eq("reg_load_cs", reg_load_cs, 1'b1);
    check_eq("reg_cs", reg_cs, swapped[31:16]);
    check_eq("reg_load_eip", reg_load_eip, 1'b0);
    check_eq("flush lines", flush_bits(), 7'b1111110);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_outputs();
    settle();
    check_eq("pending_int", pending_int, 1'b0);
    check_eq("mem_valid", mem_valid, 1'b0);
    check_eq("mem_dp_ready", mem_dp_ready, 1'b0);
    check_eq("iretd_halt", iretd_halt, 1'b0);
    check_eq("fetch_load", fetch_load, 1'b0);
    check_eq("reg_load_cs", reg_load_cs, 1'b0);
    check_eq("reg_load_eip", reg_load_eip, 1'b0);
    check_eq("reg_load_eflags", reg_load_eflags, 1'b0);
    check_eq("flush lines", flush_bits(), 7'b0);
  endtask

  task automatic jump_redirect(input logic with_cs);
    logic [31:0] addr;
    logic [31:0] cs;
    take_bits(32, addr);
    take_bits(16, cs);
    next_cycle();
    jump_load         = 1'b1;
    jump_load_address = addr;
    jump_load_cs      = with_cs;
    jump_cs           = cs[15:0];
    next_cycle();
    jump_load    = 1'b0;
    jump_load_cs = 1'b0;
    settle();
    check_eq("jump fetch_load", fetch_load, 1'b1);
    check_eq("jump fetch_load_address", fetch_load_address, addr);
    check_eq("jump flush lines", flush_bits(), 7'b1111110);
    check_eq("jump reg_load_cs", reg_load_cs, with_cs);
    if (with_cs) begin
      check_eq("jump reg_cs", reg_cs, cs[15:0]);
    end
    next_cycle();
    settle();
    check_eq("fetch_load after jump", fetch_load, 1'b0);
    check_eq("flush lines after jump", flush_bits(), 7'b0);
  endtask

  task automatic single_interrupt();
    logic [31:0] v;
    take_bits(4, v);
    pulse_lines(`SC_NUM_VEC'(1) << v);
    check_eq("pending_int after pulse", pending_int, 1'b1);
    check_eq("mem_valid before start", mem_valid, 1'b0);
    next_cycle();
    settle();
    check_eq("mem_valid one cycle after latch", mem_valid, 1'b1);
    serve_read(desc_addr(v));
    check_eq("pending_int after service", pending_int, 1'b0);
    next_cycle();
    settle();
    check_eq("fetch_load after service", fetch_load, 1'b0);
  endtask

  task automatic paired_interrupts();
    logic [31:0] a;
    logic [31:0] b;
    take_bits(4, a);
    take_bits(4, b);
    if (a == b) begin
      b = (a + 1) % `SC_NUM_VEC;
    end
    pulse_lines((`SC_NUM_VEC'(1) << a) | (`SC_NUM_VEC'(1) << b));
    serve_read(desc_addr((a < b) ? a : b));
    check_eq("pending_int with one left", pending_int, 1'b1);
    serve_read(desc_addr((a < b) ? b : a));
    check_eq("pending_int after both", pending_int, 1'b0);
  endtask

  task automatic held_interrupt();
    logic [31:0] v;
    logic [31:0] n;
    take_bits(4, v);
    take_bits(3, n);
    next_cycle();
    hold_int = 1'b1;
    pulse_lines(`SC_NUM_VEC'(1) << v);
    repeat (n + 4) begin
      check_eq("mem_valid under hold_int", mem_valid, 1'b0);
      check_eq("pending_int under hold_int", pending_int, 1'b1);
      next_cycle();
      settle();
    end
    next_cycle();
    hold_int = 1'b0;
    settle();
    serve_read(desc_addr(v));
    check_eq("pending_int after held service", pending_int, 1'b0);
  endtask

  // stack order is eip, cs, eflags
  task automatic iret_sequence();
    logic [31:0] words [3];
    logic [31:0] gap;
    for (int i = 0; i < 3; i++) begin
      take_bits(32, words[i]);
    end
    next_cycle();
    iretd = 1'b1;
    next_cycle();
    iretd = 1'b0;
    settle();
    check_eq("iretd_halt at start", iretd_halt, 1'b1);
    check_eq("flush_fetch at start", flush_fetch, 1'b1);
    for (int k = 0; k < 3; k++) begin
      take_bits(2, gap);
      repeat (gap) begin
        next_cycle();
        settle();
        check_eq("iretd_halt in gap", iretd_halt, 1'b1);
        check_eq("flush_fetch in gap", flush_fetch, 1'b1);
        check_eq("fetch_load in gap", fetch_load, 1'b0);
      end
      next_cycle();
      iretd_pop_valid = 1'b1;
      iretd_pop_data  = words[k];
      next_cycle();
      iretd_pop_valid = 1'b0;
      settle();
      check_eq("iretd_halt after pop", iretd_halt, 1'b1);
      check_eq("flush_fetch after pop", flush_fetch, 1'b1);
      check_eq("iret reg_load_cs", reg_load_cs, k == 1);
      if (k == 1) begin
        check_eq("iret reg_cs", reg_cs, words[1][15:0]);
      end
      if (k == 2) begin
        check_eq("iret fetch_load", fetch_load, 1'b1);
        check_eq("iret fetch_load_address", fetch_load_address, words[0]);
        check_eq("iret reg_load_eip", reg_load_eip, 1'b1);
        check_eq("iret reg_eip", reg_eip, words[0]);
        check_eq("iret reg_load_eflags", reg_load_eflags, 1'b1);
        check_eq("iret reg_eflags", reg_eflags, words[2]);
        check_eq("iret flush lines", flush_bits(), 7'b1111100);
      end else begin
        check_eq("iret fetch_load early", fetch_load, 1'b0);
      end
    end
    next_cycle();
    settle();
    check_eq("iretd_halt after return", iretd_halt, 1'b0);
    check_eq("flush_fetch after return", flush_fetch, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    lfsr              = 32'h14b0_6b77;
    rst               = 1'b1;
    int_vec           = '0;
    hold_int          = 1'b0;
    mem_ready         = 1'b0;
    mem_dp_valid      = 1'b0;
    mem_dp_read_data  = '0;
    iretd             = 1'b0;
    iretd_pop_valid   = 1'b0;
    iretd_pop_data    = '0;
    jump_load         = 1'b0;
    jump_load_address = '0;
    jump_load_cs      = 1'b0;
    jump_cs           = '0;
    repeat (5) @(posedge or_int_vec);
    #1;
    rst = 1'b0;
    reset_outputs();
    jump_redirect(1'b1);
    jump_redirect(1'b0);
    repeat (3) single_interrupt();
    paired_interrupts();
    held_interrupt();
    repeat (2) iret_sequence();
    next_cycle();
    $display("Verification passed");
    $finish;
  end

endmodule

/* files.f */
+incdir+logic
logic/sc_ctrl_pkg.sv
logic/sc_mem_pkg.sv
logic/int_pending.sv
logic/idt_fetch.sv
logic/iret_unwind.sv
logic/redirect_merge.sv
logic/sys_ctrl_top.sv
verif/sys_ctrl_sva.sv
verif/sys_ctrl_tb.sv

/* Bender.yml */
package:
  name: sys_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/sc_ctrl_pkg.sv
      - logic/sc_mem_pkg.sv
      - logic/int_pending.sv
      - logic/idt_fetch.sv
      - logic/iret_unwind.sv
      - logic/redirect_merge.sv
      - logic/sys_ctrl_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/sys_ctrl_sva.sv
      - verif/sys_ctrl_tb.sv
